// File: counter_host_top.f
verilog/counter_host_pkg.sv
verilog/load_pattern_lfsr.sv
verilog/trigger_payload.sv
verilog/updown_counter_fsm.sv
verilog/counter_host_top.sv
verification/tb_clock_gen.sv
verification/counter_host_assertions.sv
verification/counter_host_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the counter host testbench with Verilator and runs it once.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module counter_host_tb \
    -f counter_host_top.f \
    -o counter_host_sim

# The testbench verdict comes from its own output
sim_output=$(./obj_dir/counter_host_sim 2>&1) || true
printf '%s\n' "$sim_output"

if printf '%s\n' "$sim_output" | grep -q "Simulation passed"; then
    exit 0
fi

echo "run_sim.sh: no pass report found in the simulation output"
exit 1

// File: verification/counter_host_assertions.sv
// Concurrent checks on the counter FSM wrap flags and state register
// Bound into updown_counter_fsm from the testbench top

`timescale 1ns/1ps

module counter_host_assertions
    import counter_host_pkg::*;
(
    input logic       clk,
    input logic       rst,
    input logic [1:0] state,
    input logic       counter_overflow,
    input logic       counter_underflow
);

    // Wrap flags are exclusive
    flags_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(counter_overflow && counter_underflow))
        else $error("Overflow and underflow flags are high together");

    // A flag only shows while the FSM sits in a wrap state
    flag_in_wrap_state: assert property (@(posedge clk) disable iff (rst)
        (counter_overflow || counter_underflow) |->
            (state == st_overflow || state == st_underflow))
        else $error("Wrap flag high outside a wrap state");

    // Every 2-bit code is a state, so only an unknown code falls outside the set
    state_legal: assert property (@(posedge clk) disable iff (rst)
        !$isunknown(state))
        else $error("Counter state is unknown or outside the state set");

    // Wrap states last exactly one cycle
    wrap_returns_idle: assert property (@(posedge clk) disable iff (rst)
        (state == st_overflow || state == st_underflow) |=> (state == st_idle))
        else $error("Wrap state did not return to idle");

endmodule

// File: verification/counter_host_tb.sv
// Random-stimulus testbench for the counter host with a cycle-accurate reference model
// Compares counter_value and both wrap flags after every clock edge

`timescale 1ns/1ps

module counter_host_tb
    import counter_host_pkg::*;
();

    localparam int clk_period     = 40;
    localparam int reset_cycles   = 10;
    localparam int idle_cycles    = 20;
    localparam int mixed_cycles   = 400;
    localparam int burst_cycles   = 600;
    localparam int load_blocks    = 8;
    localparam int lfsr_wait_max  = 40;
    localparam int run_cycles     = 600;
    localparam int tail_cycles    = 4;
    localparam int block_cycles   = 17 + lfsr_wait_max + 1 + run_cycles; // Worst case per block
    localparam int total_cycles   = idle_cycles + mixed_cycles + burst_cycles
                                  + load_blocks * block_cycles + tail_cycles;
    localparam int watchdog_ns    = (reset_cycles + total_cycles + 100) * clk_period;

    logic                   clk;
    logic                   rst;
    logic                   count_enable;
    logic                   count_direction;
    logic                   load_enable;
    logic [count_width-1:0] counter_value;
    logic                   counter_overflow;
    logic                   counter_underflow;

    // Reference model state
    logic [count_width-1:0] m_lfsr;
    logic [count_width-1:0] m_counter;
    logic [count_width-1:0] m_value;
    logic                   m_overflow;
    logic                   m_underflow;
    counter_state_t         m_state;
    int                     m_cycles;  // Edges since reset release, saturating

    integer      seed;
    logic [31:0] rnd;
    int          error_count;
    int          check_count;
    int          overflow_seen;
    int          underflow_seen;

    tb_clock_gen u_clock (
        .clk (clk)
    );

    counter_host_top UUT (
        .clk               (clk),
        .rst               (rst),
        .count_enable      (count_enable),
        .count_direction   (count_direction),
        .load_enable       (load_enable),
        .counter_value     (counter_value),
        .counter_overflow  (counter_overflow),
        .counter_underflow (counter_underflow)
    );

    bind updown_counter_fsm counter_host_assertions u_assertions (
        .clk               (clk),
        .rst               (rst),
        .state             (state),
        .counter_overflow  (counter_overflow),
        .counter_underflow (counter_underflow)
    );

    // Shift left, new bit from taps 15, 11, 7 and 3
    function automatic logic [count_width-1:0] next_lfsr(input logic [count_width-1:0] value);
        return {value[count_width-2:0], ^(value & 16'h8888)};
    endfunction

    function automatic logic near_end(input logic [count_width-1:0] value);
        return (value < 16'd512) || (value > max_count - 16'd512);
    endfunction

    task automatic reset_model();
        m_lfsr      = load_seed;
        m_counter   = '0;
        m_value     = '0;
        m_overflow  = 1'b0;
        m_underflow = 1'b0;
        m_state     = st_idle;
        m_cycles    = 0;
    endtask

    // One rising edge of the whole design, using the inputs sampled at that edge
    task automatic step_model(input logic en, input logic dir, input logic ld);
        logic [count_width:0]   stepped;  // Extra bit holds carry or borrow
        logic [count_width-1:0] offset;
        offset  = (m_cycles >= int'(trigger_threshold)) ? payload_increment : '0;
        m_value = m_counter + offset;  // Output register sees the pre-edge count
        case (m_state)
            st_idle: begin
                m_overflow  = 1'b0;
                m_underflow = 1'b0;
                if (ld) begin
                    m_counter = m_lfsr;
                end else if (en) begin
                    m_state = st_count;
                end
            end
            st_count: begin
                if (!en) begin
                    m_state = st_idle;
                end else begin
                    if (dir) begin
                        stepped = {1'b0, m_counter} - (count_width+1)'(1);
                    end else begin
                        stepped = {1'b0, m_counter} + (count_width+1)'(1);
                    end
                    m_counter = stepped[count_width-1:0];
                    if (stepped[count_width]) begin
                        if (dir) begin
                            m_underflow = 1'b1;
                            m_state     = st_underflow;
                        end else begin
                            m_overflow = 1'b1;
                            m_state    = st_overflow;
                        end
                    end
                end
            end
            default: begin  // Either wrap state
                m_overflow  = 1'b0;
                m_underflow = 1'b0;
                m_state     = st_idle;
            end
        endcase
        m_lfsr = next_lfsr(m_lfsr);
        if (m_cycles < int'(trigger_threshold)) begin
            m_cycles++;
        end
    endtask

    task automatic check_outputs();
        check_count++;
        if (counter_value !== m_value) begin
            error_count++;
            $display("MISMATCH at %0t: counter_value is %h, expected %h",
                     $time, counter_value, m_value);
        end
        if (counter_overflow !== m_overflow) begin
            error_count++;
            $display("MISMATCH at %0t: counter_overflow is %b, expected %b",
                     $time, counter_overflow, m_overflow);
        end
        if (counter_underflow !== m_underflow) begin
            error_count++;
            $display("MISMATCH at %0t: counter_underflow is %b, expected %b",
                     $time, counter_underflow, m_underflow);
        end
        if (m_overflow) overflow_seen++;
        if (m_underflow) underflow_seen++;
    endtask

    // Drive at the rising edge, compare at the falling edge
    task automatic apply_inputs(input logic en, input logic dir, input logic ld);
        @(posedge clk);
        step_model(count_enable, count_direction, load_enable);
        count_enable    <= en;
        count_direction <= dir;
        load_enable     <= ld;
        @(negedge clk);
        check_outputs();
    endtask

    initial begin
        #(watchdog_ns);
        $display("Timeout: the run did not finish within %0d ns", watchdog_ns);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        int                     i;
        int                     j;
        int                     pre_wait;
        int                     wait_count;
        int                     burst_left;
        logic                   dir;
        logic                   first_wrap;
        logic [count_width-1:0] load_value;

        seed            = 32'hfb9;
        error_count     = 0;
        check_count     = 0;
        overflow_seen   = 0;
        underflow_seen  = 0;
        dir             = 1'b0;
        rst             = 1'b1;
        count_enable    = 1'b0;
        count_direction = 1'b0;
        load_enable     = 1'b0;
        reset_model();

        repeat (reset_cycles) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        if (counter_value !== '0 || counter_overflow !== 1'b0 || counter_underflow !== 1'b0) begin
            error_count++;
            $display("MISMATCH at %0t: outputs are not all zero after reset", $time);
        end

        // Idle with an occasional load
        for (i = 0; i < idle_cycles; i++) begin
            apply_inputs(1'b0, 1'b0, (i % 5) == 4);
        end

        // Short random mix of loads, counts and direction changes
        for (i = 0; i < mixed_cycles; i++) begin
            rnd = $random(seed);
            if (rnd[8:5] == 4'd0) dir = !dir;
            apply_inputs(rnd[4:3] != 2'b00, dir, rnd[2:0] == 3'd0);
        end

        // Long enable bursts split by single idle cycles
        burst_left = 0;
        for (i = 0; i < burst_cycles; i++) begin
            rnd = $random(seed);
            if (burst_left == 0) begin
                burst_left = 16 + int'(rnd[6:0]);
                dir        = rnd[7];
                apply_inputs(1'b0, dir, rnd[9] & rnd[8]);
            end else begin
                burst_left--;
                apply_inputs(1'b1, dir, 1'b0);
            end
        end

        // Forced loads close to either end, then long runs toward the wrap
        for (i = 0; i < load_blocks; i++) begin
            rnd      = $random(seed);
            pre_wait = 2 + int'(rnd[3:0]);
            for (j = 0; j < pre_wait; j++) begin
                apply_inputs(1'b0, dir, 1'b0);
            end
            wait_count = 0;
            load_value = next_lfsr(m_lfsr);  // Value the counter takes from the next load
            while (wait_count < lfsr_wait_max && !near_end(load_value)) begin
                apply_inputs(1'b0, dir, 1'b0);
                load_value = next_lfsr(m_lfsr);
                wait_count++;
            end
            dir = !load_value[count_width-1];  // High values count up
            apply_inputs(rnd[4], dir, 1'b1);   // Enable may ride along with the load
            first_wrap = 1'b1;
            for (j = 0; j < run_cycles; j++) begin
                if (m_overflow || m_underflow) begin
                    rnd = $random(seed);
                    if (first_wrap || rnd[0]) dir = !dir;
                    first_wrap = 1'b0;
                end
                apply_inputs(1'b1, dir, 1'b0);
            end
        end

        for (i = 0; i < tail_cycles; i++) begin
            apply_inputs(1'b0, dir, 1'b0);
        end

        if (overflow_seen == 0) begin
            error_count++;
            $display("Error: the counter never overflowed during the run");
        end
        if (underflow_seen == 0) begin
            error_count++;
            $display("Error: the counter never underflowed during the run");
        end

        $display("Checks: %0d, errors: %0d, overflows: %0d, underflows: %0d",
                 check_count, error_count, overflow_seen, underflow_seen);
        if (error_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: verification/tb_clock_gen.sv
// Free-running testbench clock with a 40 ns period
// Instantiated once by the counter host testbench

`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk
);

    localparam int half_period = 20;  // ns

    initial begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;
    end

endmodule

// File: verilog/counter_host_pkg.sv
// Shared widths, constants and state encoding for the counter host design
// Imported by the RTL blocks and by the testbench reference model

package counter_host_pkg;

    // Data path sizing
    localparam int count_width = 16;
    localparam logic [count_width-1:0] max_count = {count_width{1'b1}};

    // LFSR start value after reset
    localparam logic [count_width-1:0] load_seed = 16'hFF42;

    // Payload trigger point and the offset it applies once active
    localparam logic [7:0] trigger_threshold = 8'hFF;
    localparam logic [count_width-1:0] payload_increment = 16'h0002;

    // Counter FSM states
    typedef enum logic [1:0] {
        st_idle      = 2'b00,
        st_count     = 2'b01,
        st_underflow = 2'b10,
        st_overflow  = 2'b11
    } counter_state_t;

endpackage

// File: verilog/counter_host_top.sv
// Counter host top level joining the load LFSR, the counter FSM and the payload
// Inputs are level controls sampled on every rising clock edge

`timescale 1ns/1ps

module counter_host_top
    import counter_host_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   count_enable,
    input  logic                   count_direction,  // 0 up, 1 down
    input  logic                   load_enable,
    output logic [count_width-1:0] counter_value,
    output logic                   counter_overflow,
    output logic                   counter_underflow
);

    logic [count_width-1:0] load_pattern;  // LFSR to counter
    logic [count_width-1:0] value_offset;  // Payload to counter

    load_pattern_lfsr u_lfsr (
        .clk          (clk),
        .rst          (rst),
        .load_pattern (load_pattern)
    );

    trigger_payload u_payload (
        .clk          (clk),
        .rst          (rst),
        .value_offset (value_offset)
    );

    updown_counter_fsm u_counter (
        .clk               (clk),
        .rst               (rst),
        .count_enable      (count_enable),
        .count_direction   (count_direction),
        .load_enable       (load_enable),
        .load_pattern      (load_pattern),
        .value_offset      (value_offset),
        .counter_value     (counter_value),
        .counter_overflow  (counter_overflow),
        .counter_underflow (counter_underflow)
    );

endmodule

// File: verilog/load_pattern_lfsr.sv
// Free-running Fibonacci LFSR that supplies load values to the counter
// Advances on every clock with no enable

`timescale 1ns/1ps

module load_pattern_lfsr
    import counter_host_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    output logic [count_width-1:0] load_pattern
);

    logic [count_width-1:0] lfsr_q;
    logic                   feedback;

    // Taps at 15, 11, 7 and 3
    assign feedback = lfsr_q[15] ^ lfsr_q[11] ^ lfsr_q[7] ^ lfsr_q[3];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lfsr_q <= load_seed;
        end else begin
            lfsr_q <= {lfsr_q[count_width-2:0], feedback}; // New bit enters at bit 0
        end
    end

    assign load_pattern = lfsr_q;

endmodule

// File: verilog/trigger_payload.sv
// Dormant payload that counts clock cycles since reset
// Once the threshold is reached it drives a fixed offset onto the counter output

`timescale 1ns/1ps

module trigger_payload
    import counter_host_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    output logic [count_width-1:0] value_offset
);

    logic [7:0] cycle_count;
    logic [7:0] cycle_count_next;
    logic       armed;

    // Saturating count, holds at the threshold
    always_comb begin
        if (cycle_count == trigger_threshold) begin
            cycle_count_next = cycle_count;
        end else begin
            cycle_count_next = cycle_count + 8'd1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cycle_count <= 8'd0;
        end else begin
            cycle_count <= cycle_count_next;
        end
    end

    // Sticky arm flag, set on the same edge the count reaches the threshold
    // so it tracks cycle_count == trigger_threshold exactly
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            armed <= 1'b0;
        end else if (cycle_count_next == trigger_threshold) begin
            armed <= 1'b1;
        end
    end

    assign value_offset = armed ? payload_increment : '0; // Zero while dormant

endmodule

// File: verilog/updown_counter_fsm.sv
// Up/down counter with load, wrap detection and one-cycle wrap flags
// The visible output is registered as the count plus the payload offset

`timescale 1ns/1ps

module updown_counter_fsm
    import counter_host_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   count_enable,
    input  logic                   count_direction,  // 0 up, 1 down
    input  logic                   load_enable,
    input  logic [count_width-1:0] load_pattern,
    input  logic [count_width-1:0] value_offset,
    output logic [count_width-1:0] counter_value,
    output logic                   counter_overflow,
    output logic                   counter_underflow
);

    counter_state_t         state;
    logic [count_width-1:0] counter;

    // Main FSM with the internal count and both flags
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state             <= st_idle;
            counter           <= '0;
            counter_overflow  <= 1'b0;
            counter_underflow <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    counter_overflow  <= 1'b0;
                    counter_underflow <= 1'b0;
                    if (load_enable) begin
                        counter <= load_pattern; // Load wins over count
                    end else if (count_enable) begin
                        state <= st_count;       // No step on this edge
                    end
                end

                st_count: begin
                    if (!count_enable) begin
                        state <= st_idle;
                    end else if (count_direction) begin
                        // Counting down
                        if (counter == '0) begin
                            counter_underflow <= 1'b1;
                            counter           <= max_count;
                            state             <= st_underflow;
                        end else begin
                            counter <= counter - 1'b1;
                        end
                    end else begin
                        // Counting up
                        if (counter == max_count) begin
                            counter_overflow <= 1'b1;
                            counter          <= '0;
                            state            <= st_overflow;
                        end else begin
                            counter <= counter + 1'b1;
                        end
                    end
                end

                // Wrap states last one cycle and never count
                st_underflow: begin
                    counter_underflow <= 1'b0;
                    state             <= st_idle;
                end

                st_overflow: begin
                    counter_overflow <= 1'b0;
                    state            <= st_idle;
                end

                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // Output register, one cycle behind the internal count
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            counter_value <= '0;
        end else begin
            counter_value <= counter + value_offset; // Wraps modulo 2^16
        end
    end

endmodule
